/* bench/ag_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module ag_assert import ag_pkg::*; (
   input logic       clk,
   input logic       arst_n,
   input logic       stall,
   input logic       out_valid,
   input logic       out_ready,
   input ag_result_t out_res
);

   // A held result stays put until downstream takes it
   a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> $stable(out_res))
      else $error("out_res changed while held");

   a_reset_empty: assert property (@(posedge clk) $rose(arst_n) |-> !out_valid)
      else $error("out_valid high right after reset");

   // A stalled micro-op never loads an empty or draining latch
   a_no_accept_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
      stall && (!out_valid || out_ready) |=> !out_valid)
      else $error("micro-op accepted during a stall");

endmodule

bind ag_stage ag_assert u_ag_assert (
   .clk       (clk),
   .arst_n    (arst_n),
   .stall     (stall),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_res   (out_res)
);

`default_nettype wire

/* bench/ag_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ag_tb import ag_pkg::*; ();

   localparam int num_ext_stages = 3;
   localparam int num_random     = 200;
   localparam int num_hazard     = 40;
   localparam int num_items      = 2 * num_random + 8 + num_hazard;

   logic       clk;
   logic       arst_n;
   logic       in_valid;
   ag_uop_t    in_uop;
   logic       in_ready;
   logic       out_valid;
   logic       out_ready;
   ag_result_t out_res;
   stage_sb_t  ext_sb [num_ext_stages];

   logic [31:0] lfsr_state = 32'd29;
   logic        bp_on      = 1'b0;
   ag_uop_t     stim_uop;
   ag_result_t  exp_q [$];
   ag_result_t  exp_res;
   addr_t       tsp_m      = '0;
   addr_t       pps_m      = '0;
   sb_t         last_sb    = '0;
   logic        occ_m      = 1'b0;
   logic        hazard;
   int          n_in       = 0;
   int          n_out      = 0;

   ag_stage #(
      .num_ext_stages (num_ext_stages)
   ) u_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_uop    (in_uop),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_res   (out_res),
      .ext_sb    (ext_sb)
   );

   always #2 clk = ~clk;

   // Galois LFSR, one step per bit taken
   function automatic logic rand_bit();
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      return lfsr_state[0];
   endfunction

   function automatic int rand_bits(int n);
      int r;
      r = 0;
      for (int i = 0; i < n; i++) begin
         r = (r << 1) | int'(rand_bit());
      end
      return r;
   endfunction

   function automatic ag_uop_t rand_uop();
      ag_uop_t u;
      for (int i = 0; i < $bits(ag_uop_t); i++) begin
         u[i] = rand_bit();
      end
      return u;
   endfunction

   // 8-bit IDs 4 to 7 name the high byte of registers 0 to 3
   function automatic gpr_sb_t lane_bits(reg_id_t id, opsize_t size);
      gpr_sb_t m;
      int      r;
      m = '0;
      r = int'(id);
      if (size == size_8 && r < 4)
         m[3 * r] = 1'b1;
      else if (size == size_8)
         m[3 * (r - 4) + 1] = 1'b1;
      else if (size == size_16)
         m[3 * r +: 2] = 2'b11;
      else
         m[3 * r +: 3] = 3'b111;
      return m;
   endfunction

   function automatic sb_t need_mask(ag_uop_t u);
      sb_t n;
      n = '0;
      if (u.sr1_needed) n.gpr |= lane_bits(u.sr1, u.sr1_size);
      if (u.sr2_needed) n.gpr |= lane_bits(u.sr2, u.sr2_size);
      if (u.sib_en) n.gpr |= lane_bits(u.sib_i, size_32);
      if (u.seg1_needed) n.seg |= 8'h01 << u.seg1;
      if (u.seg2_needed) n.seg |= 8'h01 << u.seg2;
      if (u.mm1_needed) n.mm |= 8'h01 << u.sr1;
      if (u.mm2_needed) n.mm |= 8'h01 << u.sr2;
      return n;
   endfunction

   function automatic logic ext_hit(sb_t need);
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < num_ext_stages; i++) begin
         hit |= ext_sb[i].valid && (|(ext_sb[i].sb & need));
      end
      return hit;
   endfunction

   function automatic addr_t access_bytes(opsize_t size);
      case (size)
         size_64: return 32'd8;
         size_32: return 32'd4;
         default: return 32'd2;
      endcase
   endfunction

   function automatic ag_result_t ag_ref(ag_uop_t u, addr_t tsp, addr_t pps);
      ag_result_t r;
      addr_t      ptr;
      r = '0;
      r.neip = u.far_xfer ? u.offset[31:0] : (u.jmp_rel ? u.eip + u.offset[31:0] : u.eip);
      r.ncs  = u.far_xfer ? u.offset[47:32] : u.cs;
      case (u.mux_a)
         2'd0:    r.a_val = u.sr1_data;
         2'd1:    r.a_val = addr_t'(u.seg1_data);
         2'd2:    r.a_val = addr_t'(u.seg2_data);
         default: r.a_val = addr_t'(u.cs);
      endcase
      r.b_val = u.mux_b ? u.imm32 : u.sr2_data;
      r.ea_base_disp = (u.base_en ? u.sr1_data : '0) + (u.disp_en ? u.disp32 : '0);
      r.ea_index_seg = addr_t'(u.seg_use_cs ? u.cs : u.seg1_data) * 32'h0001_0000
                     + (u.sib_en ? u.sib_i_data << u.sib_scale : '0);
      ptr = u.stack_multi ? tsp : u.sr2_data;
      if (u.stack_push)
         r.stack_addr = ptr - access_bytes(u.mem_size);
      else if (u.stack_pop && u.stack_multi)
         r.stack_addr = ptr + pps;
      else
         r.stack_addr = ptr;
      r.int_taken = u.nmi_en || u.pf_en || u.gp_en;
      r.int_addr  = u.nmi_en ? vec_nmi : u.pf_en ? vec_page_fault : u.gp_en ? vec_gen_prot : '0;
      r.sb.gpr = (u.ld_gpr1 ? lane_bits(u.dr1, u.dr1_size) : '0)
               | (u.ld_gpr2 ? lane_bits(u.dr2, u.dr2_size) : '0);
      r.sb.seg = u.ld_seg ? 8'h01 << u.dr1 : 8'h00;
      r.sb.mm  = u.ld_mm ? 8'h01 << u.dr1 : 8'h00;
      return r;
   endfunction

   task automatic fail_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_addr(string name, addr_t got, addr_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_seg(string name, seg_t got, seg_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_sb(string name, sb_t got, sb_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic compare_result(ag_result_t exp);
      check_addr("neip", out_res.neip, exp.neip);
      check_seg("ncs", out_res.ncs, exp.ncs);
      check_addr("a_val", out_res.a_val, exp.a_val);
      check_addr("b_val", out_res.b_val, exp.b_val);
      check_addr("ea_base_disp", out_res.ea_base_disp, exp.ea_base_disp);
      check_addr("ea_index_seg", out_res.ea_index_seg, exp.ea_index_seg);
      check_addr("stack_addr", out_res.stack_addr, exp.stack_addr);
      check_addr("int_addr", out_res.int_addr, exp.int_addr);
      check_bit("int_taken", out_res.int_taken, exp.int_taken);
      check_sb("sb", out_res.sb, exp.sb);
   endtask

   task automatic drive_ready();
      out_ready = bp_on ? rand_bit() : 1'b1;
   endtask

   // Hold the uop until taken, with an optional downstream hazard for hold cycles
   task automatic send_uop(ag_uop_t u, int hold);
      int k;
      int slot;
      k    = 0;
      slot = rand_bits(2) % num_ext_stages;
      @(negedge clk);
      in_valid = 1'b1;
      in_uop   = u;
      if (hold > 0) begin
         ext_sb[slot].valid = 1'b1;
         ext_sb[slot].sb    = need_mask(u);
      end
      drive_ready();
      @(posedge clk);
      while (!in_ready) begin
         @(negedge clk);
         k++;
         if (k >= hold) ext_sb[slot] = '0;
         drive_ready();
         @(posedge clk);
      end
   endtask

   // Latch model, accept tracking and in-order compare
   always @(posedge clk) begin
      if (!arst_n) begin
         occ_m = 1'b0;
         tsp_m = '0;
         pps_m = '0;
      end else begin
         hazard = in_valid && (ext_hit(need_mask(in_uop))
                  || (occ_m && (|(last_sb & need_mask(in_uop)))));
         check_bit("out_valid", out_valid, occ_m);
         check_bit("in_ready", in_ready, (!occ_m || out_ready) && !hazard);
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               $display("Output transfer without a matching accepted micro-op");
               fail_run();
            end else begin
               compare_result(exp_q.pop_front());
               n_out++;
            end
         end
         if (in_valid && in_ready) begin
            exp_res = ag_ref(in_uop, tsp_m, pps_m);
            exp_q.push_back(exp_res);
            tsp_m   = exp_res.stack_addr;
            pps_m   = access_bytes(in_uop.mem_size);
            last_sb = exp_res.sb;
            occ_m   = 1'b1;
            n_in++;
         end else if (out_ready) begin
            occ_m = 1'b0;
         end
      end
   end

   initial begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      in_valid  = 1'b0;
      in_uop    = '0;
      out_ready = 1'b0;
      foreach (ext_sb[i]) ext_sb[i] = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      repeat (num_random) send_uop(rand_uop(), 0);
      // All eight combinations of the exception enables
      for (int i = 0; i < 8; i++) begin
         stim_uop = rand_uop();
         {stim_uop.nmi_en, stim_uop.pf_en, stim_uop.gp_en} = 3'(i);
         send_uop(stim_uop, 0);
      end
      bp_on = 1'b1;
      repeat (num_hazard) begin
         stim_uop = rand_uop();
         stim_uop.sr1_needed = 1'b1;
         send_uop(stim_uop, 1 + rand_bits(2));
      end
      repeat (num_random) send_uop(rand_uop(), 0);
      @(negedge clk);
      in_valid  = 1'b0;
      bp_on     = 1'b0;
      out_ready = 1'b1;
      while (exp_q.size() > 0) @(negedge clk);
      repeat (2) @(negedge clk);
      if (n_in == num_items && n_out == n_in && !out_valid) begin
         $display("Simulation passed");
         $finish;
      end else begin
         $display("Accepted %0d and delivered %0d micro-ops out of %0d", n_in, n_out, num_items);
         fail_run();
      end
   end

   // Generous bound of 20 cycles per item
   initial begin
      #(num_items * 20 * 4);
      $display("Watchdog timeout, the run did not finish in time");
      fail_run();
   end

endmodule

`default_nettype wire

/* build.f */
hw/ag_pkg.sv
hw/ea_calc.sv
hw/stack_addr_unit.sv
hw/dep_check.sv
hw/scoreboard_gen.sv
hw/ag_stage.sv
bench/ag_assert.sv
bench/ag_tb.sv

/* hw/ag_pkg.sv */
`default_nettype none

package ag_pkg;

   // Widths that carry a meaning
   typedef logic [31:0] addr_t;
   typedef logic [15:0] seg_t;
   typedef logic [2:0]  reg_id_t;
   typedef logic [1:0]  opsize_t;
   typedef logic [1:0]  scale_t;

   // Operand-size codes
   localparam opsize_t size_8  = 2'd0;
   localparam opsize_t size_16 = 2'd1;
   localparam opsize_t size_32 = 2'd2;
   localparam opsize_t size_64 = 2'd3;

   // Scoreboards: three GPR bits per register (byte 0, byte 1, upper half)
   typedef logic [23:0] gpr_sb_t;
   typedef logic [7:0]  seg_sb_t;
   typedef logic [7:0]  mm_sb_t;

   typedef struct packed {
      gpr_sb_t gpr;
      seg_sb_t seg;
      mm_sb_t  mm;
   } sb_t;

   typedef struct packed {
      logic valid;
      sb_t  sb;
   } stage_sb_t;

   // IDT entry addresses, 8 bytes per gate
   localparam addr_t vec_nmi        = 32'h0000_0010;
   localparam addr_t vec_page_fault = 32'h0000_0070;
   localparam addr_t vec_gen_prot   = 32'h0000_0068;

   typedef struct packed {
      addr_t       eip;
      seg_t        cs;
      logic [47:0] offset;
      reg_id_t     sr1;
      reg_id_t     sr2;
      reg_id_t     sib_i;
      reg_id_t     seg1;
      reg_id_t     seg2;
      opsize_t     sr1_size;
      opsize_t     sr2_size;
      logic        sr1_needed;
      logic        sr2_needed;
      logic        seg1_needed;
      logic        seg2_needed;
      logic        mm1_needed;
      logic        mm2_needed;
      addr_t       sr1_data;
      addr_t       sr2_data;
      addr_t       sib_i_data;
      seg_t        seg1_data;
      seg_t        seg2_data;
      addr_t       imm32;
      addr_t       disp32;
      logic        sib_en;
      logic        disp_en;
      logic        base_en;
      scale_t      sib_scale;
      logic        seg_use_cs;
      logic        jmp_rel;
      logic        far_xfer;
      logic [1:0]  mux_a;
      logic        mux_b;
      logic        stack_push;
      logic        stack_pop;
      logic        stack_multi;
      opsize_t     mem_size;
      reg_id_t     dr1;
      reg_id_t     dr2;
      opsize_t     dr1_size;
      opsize_t     dr2_size;
      logic        ld_gpr1;
      logic        ld_gpr2;
      logic        ld_seg;
      logic        ld_mm;
      logic        nmi_en;
      logic        pf_en;
      logic        gp_en;
   } ag_uop_t;

   typedef struct packed {
      addr_t neip;
      seg_t  ncs;
      addr_t a_val;
      addr_t b_val;
      addr_t ea_base_disp;
      addr_t ea_index_seg;
      addr_t stack_addr;
      addr_t int_addr;
      logic  int_taken;
      sb_t   sb;
   } ag_result_t;

   // Byte lanes touched by a GPR access of the given size
   // IDs 4 to 7 at 8 bits are the high bytes AH, CH, DH, BH
   function automatic gpr_sb_t gpr_lanes(reg_id_t id, opsize_t size);
      gpr_sb_t lanes;
      int      base;
      lanes = '0;
      base  = 3 * int'(id);
      case (size)
         size_8: begin
            if (id[2]) begin
               lanes[3 * int'(id[1:0]) + 1] = 1'b1;
            end else begin
               lanes[base] = 1'b1;
            end
         end
         size_16: lanes[base +: 2] = 2'b11;
         default: lanes[base +: 3] = 3'b111;
      endcase
      return lanes;
   endfunction

   function automatic logic [7:0] onehot8(reg_id_t id);
      return 8'b1 << id;
   endfunction

endpackage

`default_nettype wire

/* hw/ag_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module ag_stage import ag_pkg::*; #(
   parameter int num_ext_stages = 3
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       in_valid,
   input  ag_uop_t    in_uop,
   output logic       in_ready,
   output logic       out_valid,
   input  logic       out_ready,
   output ag_result_t out_res,
   input  stage_sb_t  ext_sb [num_ext_stages]
);

   logic       stall;
   logic       accept;
   stage_sb_t  own_sb;
   ag_result_t res_next;
   addr_t      ea_base_disp;
   addr_t      ea_index_seg;
   addr_t      stack_addr;
   sb_t        dest_sb;
   addr_t      rel_target;

   // Handshake
   assign in_ready = (!out_valid || out_ready) && !stall;
   assign accept   = in_valid && in_ready;

   // The occupied latch is checked like any downstream stage
   assign own_sb.valid = out_valid;
   assign own_sb.sb    = out_res.sb;

   ea_calc u_ea_calc (
      .uop       (in_uop),
      .base_disp (ea_base_disp),
      .index_seg (ea_index_seg)
   );

   stack_addr_unit u_stack_addr_unit (
      .clk        (clk),
      .arst_n     (arst_n),
      .accept     (accept),
      .uop        (in_uop),
      .stack_addr (stack_addr)
   );

   dep_check #(
      .num_ext_stages (num_ext_stages)
   ) u_dep_check (
      .uop_valid (in_valid),
      .uop       (in_uop),
      .ext_sb    (ext_sb),
      .own_sb    (own_sb),
      .stall     (stall)
   );

   scoreboard_gen u_scoreboard_gen (
      .uop (in_uop),
      .sb  (dest_sb)
   );

   assign rel_target = in_uop.eip + in_uop.offset[31:0];

   always_comb begin
      res_next = '0;

      // Far transfers load EIP and CS from the 48-bit pointer
      if (in_uop.far_xfer) begin
         res_next.neip = in_uop.offset[31:0];
         res_next.ncs  = in_uop.offset[47:32];
      end else begin
         res_next.neip = in_uop.jmp_rel ? rel_target : in_uop.eip;
         res_next.ncs  = in_uop.cs;
      end

      case (in_uop.mux_a)
         2'd0:    res_next.a_val = in_uop.sr1_data;
         2'd1:    res_next.a_val = {16'h0000, in_uop.seg1_data};
         2'd2:    res_next.a_val = {16'h0000, in_uop.seg2_data};
         default: res_next.a_val = {16'h0000, in_uop.cs};
      endcase
      res_next.b_val = in_uop.mux_b ? in_uop.imm32 : in_uop.sr2_data;

      res_next.ea_base_disp = ea_base_disp;
      res_next.ea_index_seg = ea_index_seg;
      res_next.stack_addr   = stack_addr;

      // NMI wins over page fault, page fault over GP
      if (in_uop.nmi_en) begin
         res_next.int_addr = vec_nmi;
      end else if (in_uop.pf_en) begin
         res_next.int_addr = vec_page_fault;
      end else if (in_uop.gp_en) begin
         res_next.int_addr = vec_gen_prot;
      end else begin
         res_next.int_addr = '0;
      end
      res_next.int_taken = in_uop.nmi_en | in_uop.pf_en | in_uop.gp_en;

      res_next.sb = dest_sb;
   end

   // Output latch
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (accept) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         out_res <= res_next;
      end
   end

endmodule

`default_nettype wire

/* hw/dep_check.sv */
`timescale 1ns/100ps
`default_nettype none

module dep_check import ag_pkg::*; #(
   parameter int num_ext_stages = 3
) (
   input  logic      uop_valid,
   input  ag_uop_t   uop,
   input  stage_sb_t ext_sb [num_ext_stages],
   input  stage_sb_t own_sb,
   output logic      stall
);

   gpr_sb_t sr1_mask;
   gpr_sb_t sr2_mask;
   gpr_sb_t sib_mask;
   sb_t     need;
   logic    hit;

   // Source lanes, each gated by its need flag
   assign sr1_mask = uop.sr1_needed ? gpr_lanes(uop.sr1, uop.sr1_size) : '0;
   assign sr2_mask = uop.sr2_needed ? gpr_lanes(uop.sr2, uop.sr2_size) : '0;

   // Index register is always read as 32 bits
   assign sib_mask = uop.sib_en ? gpr_lanes(uop.sib_i, size_32) : '0;

   always_comb begin
      need.gpr = sr1_mask | sr2_mask | sib_mask;
      need.seg = (uop.seg1_needed ? onehot8(uop.seg1) : 8'h00)
               | (uop.seg2_needed ? onehot8(uop.seg2) : 8'h00);
      // MM sources share the SR1 and SR2 register IDs
      need.mm  = (uop.mm1_needed ? onehot8(uop.sr1) : 8'h00)
               | (uop.mm2_needed ? onehot8(uop.sr2) : 8'h00);
   end

   function automatic logic overlaps(stage_sb_t s, sb_t mask);
      logic gpr_hit;
      logic seg_hit;
      logic mm_hit;
      gpr_hit = |(s.sb.gpr & mask.gpr);
      seg_hit = |(s.sb.seg & mask.seg);
      mm_hit  = |(s.sb.mm & mask.mm);
      return s.valid && (gpr_hit || seg_hit || mm_hit);
   endfunction

   // Own latch entry counts as one more in-flight stage
   always_comb begin
      hit = overlaps(own_sb, need);
      for (int i = 0; i < num_ext_stages; i++) begin
         hit = hit | overlaps(ext_sb[i], need);
      end
   end

   assign stall = uop_valid & hit;

endmodule

`default_nettype wire

/* hw/ea_calc.sv */
`timescale 1ns/100ps
`default_nettype none

module ea_calc import ag_pkg::*; (
   input  ag_uop_t uop,
   output addr_t   base_disp,
   output addr_t   index_seg
);

   addr_t base_val;
   addr_t disp_val;
   seg_t  seg_val;
   addr_t scaled_idx;

   // First partial sum, base register plus displacement
   assign base_val  = uop.base_en ? uop.sr1_data : '0;
   assign disp_val  = uop.disp_en ? uop.disp32 : '0;
   assign base_disp = base_val + disp_val;

   // Segment base is the selector value shifted into the upper half
   assign seg_val = uop.seg_use_cs ? uop.cs : uop.seg1_data;

   // SIB index scaled by 1, 2, 4 or 8
   assign scaled_idx = uop.sib_en ? (uop.sib_i_data << uop.sib_scale) : '0;

   assign index_seg = {seg_val, 16'h0000} + scaled_idx;

endmodule

`default_nettype wire

/* hw/scoreboard_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module scoreboard_gen import ag_pkg::*; (
   input  ag_uop_t uop,
   output sb_t     sb
);

   gpr_sb_t dr1_mask;
   gpr_sb_t dr2_mask;

   assign dr1_mask = uop.ld_gpr1 ? gpr_lanes(uop.dr1, uop.dr1_size) : '0;
   assign dr2_mask = uop.ld_gpr2 ? gpr_lanes(uop.dr2, uop.dr2_size) : '0;

   // Segment and MM writes only ever target DR1
   assign sb.gpr = dr1_mask | dr2_mask;
   assign sb.seg = uop.ld_seg ? onehot8(uop.dr1) : '0;
   assign sb.mm  = uop.ld_mm ? onehot8(uop.dr1) : '0;

endmodule

`default_nettype wire

/* hw/stack_addr_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module stack_addr_unit import ag_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    accept,
   input  ag_uop_t uop,
   output addr_t   stack_addr
);

   addr_t temp_sp;
   addr_t prev_pop_size;
   addr_t start_ptr;
   addr_t access_bytes;
   addr_t adjust;

   // Stack accesses are at least one word wide
   always_comb begin
      case (uop.mem_size)
         size_32: access_bytes = 32'd4;
         size_64: access_bytes = 32'd8;
         default: access_bytes = 32'd2;
      endcase
   end

   // Multi-access sequences continue from the last computed address
   assign start_ptr = uop.stack_multi ? temp_sp : uop.sr2_data;

   always_comb begin
      if (uop.stack_push) begin
         adjust = '0 - access_bytes;
      end else if (uop.stack_pop && uop.stack_multi) begin
         adjust = prev_pop_size;
      end else begin
         // Plain pop reads at the pointer itself
         adjust = '0;
      end
   end

   assign stack_addr = start_ptr + adjust;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         temp_sp       <= '0;
         prev_pop_size <= '0;
      end else if (accept) begin
         temp_sp       <= stack_addr;
         prev_pop_size <= access_bytes;
      end
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the ag_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f build.f --top-module ag_tb -o ag_tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/ag_tb_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Simulation failed" "$log"; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi
if ! grep -q "Simulation passed" "$log"; then
   echo "No pass report found in $log"
   exit 1
fi
exit 0
